/* include/sb_defs.svh */
`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

`define SB_NUM_REGS     32
`define SB_REG_W        5
`define SB_INST_W       32

// major opcodes
`define SB_OPC_OP       7'b0110011
`define SB_OPC_OPIMM    7'b0010011
`define SB_OPC_LOAD     7'b0000011
`define SB_OPC_STORE    7'b0100011
`define SB_OPC_LUI      7'b0110111
`define SB_OPC_AUIPC    7'b0010111

// funct7
`define SB_F7_BASE      7'h00
`define SB_F7_ALT       7'h20   // sub, sra, srai
`define SB_F7_MULDIV    7'h01

// funct3, alu
`define SB_F3_ADD       3'h0
`define SB_F3_SLL       3'h1
`define SB_F3_SLT       3'h2
`define SB_F3_SLTU      3'h3
`define SB_F3_XOR       3'h4
`define SB_F3_SR        3'h5    // srl and sra
`define SB_F3_OR        3'h6
`define SB_F3_AND       3'h7

// funct3, load/store width
`define SB_F3_B         3'h0
`define SB_F3_H         3'h1
`define SB_F3_W         3'h2
`define SB_F3_BU        3'h4
`define SB_F3_HU        3'h5

// funct3, multiply
`define SB_F3_MUL       3'h0
`define SB_F3_MULH      3'h1
`define SB_F3_MULHSU    3'h2
`define SB_F3_MULHU     3'h3

`endif

/* design/sb_pkg.sv */
package sb_pkg;

    typedef enum logic [2:0] {
        FU_NONE = 3'd0,    // no pending writer
        FU_ALU  = 3'd1,
        FU_MEM  = 3'd2,
        FU_MUL  = 3'd3
    } fu_e;

    // one code space over all three units
    typedef enum logic [5:0] {
        OP_ADD = 6'd0,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_AUIPC,
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_SLTI,
        OP_SLTIU,
        OP_LB,      // mem unit from here
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_MUL,     // mul unit
        OP_MULH,
        OP_MULHSU,
        OP_MULHU
    } op_e;

    typedef enum logic [1:0] {
        WS_ALU = 2'd0,
        WS_MEM = 2'd1,
        WS_MUL = 2'd2
    } wsel_e;

endpackage

/* design/inst_decoder.sv */
`include "sb_defs.svh"

module inst_decoder (
    input  logic [`SB_INST_W-1:0] inst,
    output sb_pkg::fu_e           use_fu,
    output sb_pkg::op_e           op,
    output logic [`SB_REG_W-1:0]  dst,
    output logic [`SB_REG_W-1:0]  src1,
    output logic [`SB_REG_W-1:0]  src2,
    output logic                  legal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       has_rd;
    logic       has_rs1;
    logic       has_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = (funct7 == `SB_F7_ALT);

    always_comb begin
        use_fu  = sb_pkg::FU_NONE;
        op      = sb_pkg::OP_ADD;
        legal   = 1'b0;
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        case (opcode)
            `SB_OPC_OP: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                if (funct7 == `SB_F7_MULDIV) begin
                    use_fu = sb_pkg::FU_MUL;
                    legal  = 1'b1;
                    case (funct3)
                        `SB_F3_MUL:    op = sb_pkg::OP_MUL;
                        `SB_F3_MULH:   op = sb_pkg::OP_MULH;
                        `SB_F3_MULHSU: op = sb_pkg::OP_MULHSU;
                        `SB_F3_MULHU:  op = sb_pkg::OP_MULHU;
                        default:       legal = 1'b0;    // div/rem, no unit
                    endcase
                end else if (funct7 == `SB_F7_BASE || alt) begin
                    use_fu = sb_pkg::FU_ALU;
                    legal  = 1'b1;
                    case (funct3)
                        `SB_F3_ADD:  op = alt ? sb_pkg::OP_SUB : sb_pkg::OP_ADD;
                        `SB_F3_SLL:  op = sb_pkg::OP_SLL;
                        `SB_F3_SLT:  op = sb_pkg::OP_SLT;
                        `SB_F3_SLTU: op = sb_pkg::OP_SLTU;
                        `SB_F3_XOR:  op = sb_pkg::OP_XOR;
                        `SB_F3_SR:   op = alt ? sb_pkg::OP_SRA : sb_pkg::OP_SRL;
                        `SB_F3_OR:   op = sb_pkg::OP_OR;
                        default:     op = sb_pkg::OP_AND;
                    endcase
                    // only add and shift right have an alternate form
                    if (alt && funct3 != `SB_F3_ADD && funct3 != `SB_F3_SR) begin
                        legal = 1'b0;
                    end
                end
            end
            `SB_OPC_OPIMM: begin
                use_fu  = sb_pkg::FU_ALU;
                legal   = 1'b1;
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                case (funct3)
                    `SB_F3_ADD:  op = sb_pkg::OP_ADDI;
                    `SB_F3_SLT:  op = sb_pkg::OP_SLTI;
                    `SB_F3_SLTU: op = sb_pkg::OP_SLTIU;
                    `SB_F3_XOR:  op = sb_pkg::OP_XORI;
                    `SB_F3_OR:   op = sb_pkg::OP_ORI;
                    `SB_F3_AND:  op = sb_pkg::OP_ANDI;
                    `SB_F3_SLL: begin
                        op    = sb_pkg::OP_SLLI;
                        legal = (funct7 == `SB_F7_BASE);
                    end
                    default: begin
                        op    = alt ? sb_pkg::OP_SRAI : sb_pkg::OP_SRLI;
                        legal = (funct7 == `SB_F7_BASE) || alt;
                    end
                endcase
            end
            `SB_OPC_LOAD: begin
                use_fu  = sb_pkg::FU_MEM;
                legal   = 1'b1;
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                case (funct3)
                    `SB_F3_B:  op = sb_pkg::OP_LB;
                    `SB_F3_H:  op = sb_pkg::OP_LH;
                    `SB_F3_W:  op = sb_pkg::OP_LW;
                    `SB_F3_BU: op = sb_pkg::OP_LBU;
                    `SB_F3_HU: op = sb_pkg::OP_LHU;
                    default:   legal = 1'b0;
                endcase
            end
            `SB_OPC_STORE: begin
                use_fu  = sb_pkg::FU_MEM;
                legal   = 1'b1;
                has_rs1 = 1'b1;     // base
                has_rs2 = 1'b1;     // store data
                case (funct3)
                    `SB_F3_B: op = sb_pkg::OP_SB;
                    `SB_F3_H: op = sb_pkg::OP_SH;
                    `SB_F3_W: op = sb_pkg::OP_SW;
                    default:  legal = 1'b0;
                endcase
            end
            `SB_OPC_LUI: begin
                use_fu = sb_pkg::FU_ALU;
                op     = sb_pkg::OP_LUI;
                legal  = 1'b1;
                has_rd = 1'b1;
            end
            `SB_OPC_AUIPC: begin
                use_fu = sb_pkg::FU_ALU;
                op     = sb_pkg::OP_AUIPC;
                legal  = 1'b1;
                has_rd = 1'b1;
            end
            default: ;
        endcase
        if (!legal) begin
            use_fu = sb_pkg::FU_NONE;
        end
    end

    // unused fields read as x0
    assign dst  = (legal && has_rd)  ? inst[11:7]  : '0;
    assign src1 = (legal && has_rs1) ? inst[19:15] : '0;
    assign src2 = (legal && has_rs2) ? inst[24:20] : '0;

endmodule

/* design/fu_status_table.sv */
`include "sb_defs.svh"

module fu_status_table (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  sb_pkg::fu_e           use_fu,
    input  sb_pkg::op_e           op,
    input  logic [`SB_REG_W-1:0]  dst,
    input  logic [`SB_REG_W-1:0]  src1,
    input  logic [`SB_REG_W-1:0]  src2,
    input  logic                  legal,
    input  sb_pkg::fu_e           ro_fu,
    input  sb_pkg::fu_e           wb_fu,
    input  logic                  alu_done,
    input  logic                  mem_done,
    input  logic                  mul_done,
    output logic                  issue_ready,
    output logic [2:0]            busy,         // bit 0 alu, 1 mem, 2 mul
    output logic [2:0]            done_flag,
    output logic [2:0]            rdy1,
    output logic [2:0]            rdy2,
    output sb_pkg::op_e           ent_op [3],
    output logic [`SB_REG_W-1:0]  ent_dst [3],
    output logic [`SB_REG_W-1:0]  ent_src1 [3],
    output logic [`SB_REG_W-1:0]  ent_src2 [3]
);

    sb_pkg::fu_e rrs [`SB_NUM_REGS];   // pending writer per register
    sb_pkg::fu_e fu1 [3];              // producer still owed to each source
    sb_pkg::fu_e fu2 [3];
    sb_pkg::fu_e src1_fu;
    sb_pkg::fu_e src2_fu;
    logic [1:0]  iss_idx;
    logic [1:0]  ro_idx;
    logic [1:0]  wb_idx;
    logic [2:0]  done_in;
    logic        stall;
    logic        issue;
    logic        src1_rdy;
    logic        src2_rdy;

    // entry index is the unit code minus one
    assign iss_idx = use_fu[1:0] - 2'd1;
    assign ro_idx  = ro_fu[1:0] - 2'd1;
    assign wb_idx  = wb_fu[1:0] - 2'd1;
    assign done_in = {mul_done, mem_done, alu_done};

    // structural hazard or WAW
    assign stall = legal && (busy[iss_idx] || (dst != '0 && rrs[dst] != sb_pkg::FU_NONE));
    assign issue_ready = !stall;
    assign issue = inst_valid && issue_ready && legal;   // illegal words just drop

    // a producer retiring this very edge counts as finished
    assign src1_fu  = rrs[src1];
    assign src2_fu  = rrs[src2];
    assign src1_rdy = (src1_fu == sb_pkg::FU_NONE) || (src1_fu == wb_fu);
    assign src2_rdy = (src2_fu == sb_pkg::FU_NONE) || (src2_fu == wb_fu);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= '0;
            done_flag <= '0;
            rdy1      <= '0;
            rdy2      <= '0;
            for (int i = 0; i < 3; i++) begin
                fu1[i] <= sb_pkg::FU_NONE;
                fu2[i] <= sb_pkg::FU_NONE;
            end
            for (int r = 0; r < `SB_NUM_REGS; r++) begin
                rrs[r] <= sb_pkg::FU_NONE;
            end
        end else begin
            done_flag <= done_flag | done_in;

            // operands read, entry now executing
            if (ro_fu != sb_pkg::FU_NONE) begin
                rdy1[ro_idx] <= 1'b0;
                rdy2[ro_idx] <= 1'b0;
            end

            if (wb_fu != sb_pkg::FU_NONE) begin
                busy[wb_idx]      <= 1'b0;
                done_flag[wb_idx] <= 1'b0;
                if (ent_dst[wb_idx] != '0) begin
                    rrs[ent_dst[wb_idx]] <= sb_pkg::FU_NONE;
                end
                // wake consumers of this result
                for (int i = 0; i < 3; i++) begin
                    if (fu1[i] == wb_fu) begin
                        rdy1[i] <= 1'b1;
                        fu1[i]  <= sb_pkg::FU_NONE;
                    end
                    if (fu2[i] == wb_fu) begin
                        rdy2[i] <= 1'b1;
                        fu2[i]  <= sb_pkg::FU_NONE;
                    end
                end
            end

            if (issue) begin
                busy[iss_idx] <= 1'b1;
                rdy1[iss_idx] <= src1_rdy;
                rdy2[iss_idx] <= src2_rdy;
                fu1[iss_idx]  <= src1_rdy ? sb_pkg::FU_NONE : src1_fu;
                fu2[iss_idx]  <= src2_rdy ? sb_pkg::FU_NONE : src2_fu;
                if (dst != '0) begin
                    rrs[dst] <= use_fu;
                end
            end
        end
    end

    // entry payload, only meaningful while busy
    always_ff @(posedge clk) begin
        if (issue) begin
            ent_op[iss_idx]   <= op;
            ent_dst[iss_idx]  <= dst;
            ent_src1[iss_idx] <= src1;
            ent_src2[iss_idx] <= src2;
        end
    end

endmodule

/* design/operand_dispatch.sv */
`include "sb_defs.svh"

module operand_dispatch (
    input  logic [2:0]            rdy1,
    input  logic [2:0]            rdy2,
    input  sb_pkg::op_e           ent_op [3],
    input  logic [`SB_REG_W-1:0]  ent_src1 [3],
    input  logic [`SB_REG_W-1:0]  ent_src2 [3],
    output sb_pkg::fu_e           ro_fu,
    output logic                  alu_en,
    output logic                  mem_en,
    output logic                  mul_en,
    output sb_pkg::op_e           alu_op,
    output sb_pkg::op_e           mem_op,
    output sb_pkg::op_e           mul_op,
    output logic [`SB_REG_W-1:0]  rs1_ctrl,
    output logic [`SB_REG_W-1:0]  rs2_ctrl
);

    logic [2:0] both_rdy;
    logic [1:0] sel;    // granted entry

    assign both_rdy = rdy1 & rdy2;

    always_comb begin
        ro_fu    = sb_pkg::FU_NONE;
        alu_en   = 1'b0;
        mem_en   = 1'b0;
        mul_en   = 1'b0;
        alu_op   = sb_pkg::OP_ADD;
        mem_op   = sb_pkg::OP_ADD;
        mul_op   = sb_pkg::OP_ADD;
        sel      = 2'd0;
        // alu first, then mem, then mul
        if (both_rdy[0]) begin
            ro_fu  = sb_pkg::FU_ALU;
            alu_en = 1'b1;
            alu_op = ent_op[0];
        end else if (both_rdy[1]) begin
            ro_fu  = sb_pkg::FU_MEM;
            mem_en = 1'b1;
            mem_op = ent_op[1];
            sel    = 2'd1;
        end else if (both_rdy[2]) begin
            ro_fu  = sb_pkg::FU_MUL;
            mul_en = 1'b1;
            mul_op = ent_op[2];
            sel    = 2'd2;
        end
        rs1_ctrl = (|both_rdy) ? ent_src1[sel] : '0;
        rs2_ctrl = (|both_rdy) ? ent_src2[sel] : '0;
    end

endmodule

/* design/writeback_arbiter.sv */
`include "sb_defs.svh"

module writeback_arbiter (
    input  logic [2:0]            done_flag,
    input  logic [2:0]            rdy1,
    input  logic [2:0]            rdy2,
    input  logic [`SB_REG_W-1:0]  ent_dst [3],
    input  logic [`SB_REG_W-1:0]  ent_src1 [3],
    input  logic [`SB_REG_W-1:0]  ent_src2 [3],
    output sb_pkg::fu_e           wb_fu,
    output logic                  reg_write,
    output logic [`SB_REG_W-1:0]  rd_ctrl,
    output sb_pkg::wsel_e         write_sel
);

    logic [2:0] war;        // someone still has to read this unit's dst
    logic [2:0] can_wb;

    // a ready but unread source matching dst blocks the write
    always_comb begin
        war = '0;
        for (int u = 0; u < 3; u++) begin
            for (int j = 0; j < 3; j++) begin
                if (j != u && ent_dst[u] != '0 &&
                    ((rdy1[j] && ent_src1[j] == ent_dst[u]) ||
                     (rdy2[j] && ent_src2[j] == ent_dst[u]))) begin
                    war[u] = 1'b1;
                end
            end
        end
    end

    assign can_wb = done_flag & ~war;

    always_comb begin
        wb_fu     = sb_pkg::FU_NONE;
        rd_ctrl   = '0;
        write_sel = sb_pkg::WS_ALU;
        if (can_wb[0]) begin
            wb_fu   = sb_pkg::FU_ALU;
            rd_ctrl = ent_dst[0];
        end else if (can_wb[1]) begin
            wb_fu     = sb_pkg::FU_MEM;
            rd_ctrl   = ent_dst[1];
            write_sel = sb_pkg::WS_MEM;
        end else if (can_wb[2]) begin
            wb_fu     = sb_pkg::FU_MUL;
            rd_ctrl   = ent_dst[2];
            write_sel = sb_pkg::WS_MUL;
        end
        // stores and x0 targets retire without a register write
        reg_write = (rd_ctrl != '0);
    end

endmodule

/* design/scoreboard_top.sv */
`include "sb_defs.svh"

module scoreboard_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`SB_INST_W-1:0] inst,
    input  logic                  inst_valid,
    input  logic                  alu_done,
    input  logic                  mem_done,
    input  logic                  mul_done,
    output logic                  issue_ready,
    output logic                  alu_en,
    output logic                  mem_en,
    output logic                  mul_en,
    output sb_pkg::op_e           alu_op,
    output sb_pkg::op_e           mem_op,
    output sb_pkg::op_e           mul_op,
    output logic [`SB_REG_W-1:0]  rs1_ctrl,
    output logic [`SB_REG_W-1:0]  rs2_ctrl,
    output logic                  reg_write,
    output logic [`SB_REG_W-1:0]  rd_ctrl,
    output sb_pkg::wsel_e         write_sel
);

    sb_pkg::fu_e          use_fu;
    sb_pkg::op_e          op;
    logic [`SB_REG_W-1:0] dst;
    logic [`SB_REG_W-1:0] src1;
    logic [`SB_REG_W-1:0] src2;
    logic                 legal;
    sb_pkg::fu_e          ro_fu;
    sb_pkg::fu_e          wb_fu;
    logic [2:0]           done_flag;
    logic [2:0]           rdy1;
    logic [2:0]           rdy2;
    sb_pkg::op_e          ent_op [3];
    logic [`SB_REG_W-1:0] ent_dst [3];
    logic [`SB_REG_W-1:0] ent_src1 [3];
    logic [`SB_REG_W-1:0] ent_src2 [3];

    inst_decoder u_dec (
        .inst   (inst),
        .use_fu (use_fu),
        .op     (op),
        .dst    (dst),
        .src1   (src1),
        .src2   (src2),
        .legal  (legal)
    );

    fu_status_table u_fst (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .use_fu      (use_fu),
        .op          (op),
        .dst         (dst),
        .src1        (src1),
        .src2        (src2),
        .legal       (legal),
        .ro_fu       (ro_fu),
        .wb_fu       (wb_fu),
        .alu_done    (alu_done),
        .mem_done    (mem_done),
        .mul_done    (mul_done),
        .issue_ready (issue_ready),
        .busy        (),            // table internal
        .done_flag   (done_flag),
        .rdy1        (rdy1),
        .rdy2        (rdy2),
        .ent_op      (ent_op),
        .ent_dst     (ent_dst),
        .ent_src1    (ent_src1),
        .ent_src2    (ent_src2)
    );

    operand_dispatch u_ro (
        .rdy1     (rdy1),
        .rdy2     (rdy2),
        .ent_op   (ent_op),
        .ent_src1 (ent_src1),
        .ent_src2 (ent_src2),
        .ro_fu    (ro_fu),
        .alu_en   (alu_en),
        .mem_en   (mem_en),
        .mul_en   (mul_en),
        .alu_op   (alu_op),
        .mem_op   (mem_op),
        .mul_op   (mul_op),
        .rs1_ctrl (rs1_ctrl),
        .rs2_ctrl (rs2_ctrl)
    );

    writeback_arbiter u_wb (
        .done_flag (done_flag),
        .rdy1      (rdy1),
        .rdy2      (rdy2),
        .ent_dst   (ent_dst),
        .ent_src1  (ent_src1),
        .ent_src2  (ent_src2),
        .wb_fu     (wb_fu),
        .reg_write (reg_write),
        .rd_ctrl   (rd_ctrl),
        .write_sel (write_sel)
    );

endmodule

/* tests/sb_props.sv */
module sb_props (
    input logic        clk,
    input logic        rst,
    input logic [2:0]  busy,
    input logic [2:0]  done_flag,
    input sb_pkg::fu_e ro_fu
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [2:0] ro_vec;    // one-hot view of the read-operand grant

    assign ro_vec = {ro_fu == sb_pkg::FU_MUL, ro_fu == sb_pkg::FU_MEM, ro_fu == sb_pkg::FU_ALU};

    // ready bits clear at the grant edge, so no unit is granted twice in a row
    a_one_enable: assert property (@(posedge clk) disable iff (rst)
        (ro_vec & $past(ro_vec)) == 3'b000)
        else $error("unit enable held for more than one cycle");

    a_grant_busy: assert property (@(posedge clk) disable iff (rst)
        (ro_vec & ~busy) == 3'b000)
        else $error("read-operand grant to an idle unit");

    a_done_busy: assert property (@(posedge clk) disable iff (rst)
        (done_flag & ~busy) == 3'b000)
        else $error("done flag set on an idle unit");

endmodule

bind fu_status_table sb_props u_props (.*);

/* tests/sb_checker.sv */
module sb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid,
    input  logic        issue_ready,
    input  sb_pkg::fu_e exp_fu,     // decode expected for the word on inst
    input  sb_pkg::op_e exp_op,
    input  logic [4:0]  exp_rd,
    input  logic [4:0]  exp_rs1,
    input  logic [4:0]  exp_rs2,
    input  logic        alu_en,
    input  logic        mem_en,
    input  logic        mul_en,
    input  sb_pkg::op_e alu_op,
    input  sb_pkg::op_e mem_op,
    input  sb_pkg::op_e mul_op,
    input  logic [4:0]  rs1_ctrl,
    input  logic [4:0]  rs2_ctrl,
    input  logic        reg_write,
    input  logic [4:0]  rd_ctrl,
    input  sb_pkg::wsel_e write_sel,
    input  logic        alu_done,
    input  logic        mem_done,
    input  logic        mul_done,
    output int          errors,
    output int          issued,
    output int          wb_count,
    output logic        drained
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        m_busy [3];
    logic        m_read [3];
    logic        m_done [3];
    logic [4:0]  m_rd [3];
    logic [4:0]  m_rs1 [3];
    logic [4:0]  m_rs2 [3];
    sb_pkg::op_e m_op [3];
    int          m_seq [3];
    logic [2:0]  m_dep [3];         // producers still owed, one bit per unit
    sb_pkg::fu_e pend [32];
    logic [4:0]  rd_q [3][$];       // issued destinations per unit, in issue order

    assign drained = !(m_busy[0] || m_busy[1] || m_busy[2]);

    task automatic report_value(string name, int exp_val, int act_val);
        if (exp_val != act_val) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic report_error(string msg);
        $display("ERROR: %s at %0t", msg, $time);
        errors++;
    endtask

    function automatic sb_pkg::op_e op_of(int u);
        case (u)
            0:       return alu_op;
            1:       return mem_op;
            default: return mul_op;
        endcase
    endfunction

    always @(posedge clk) begin : watch
        logic [2:0] en;
        logic [2:0] dn;
        logic       stall_exp;
        int         w;
        int         u;
        en = {mul_en, mem_en, alu_en};
        dn = {mul_done, mem_done, alu_done};
        w  = -1;
        if (rst) begin
            errors   = 0;
            issued   = 0;
            wb_count = 0;
            for (int i = 0; i < 3; i++) begin
                m_busy[i] = 1'b0;
                m_read[i] = 1'b0;
                m_done[i] = 1'b0;
                m_dep[i]  = 3'b000;
                rd_q[i].delete();
            end
            for (int r = 0; r < 32; r++) begin
                pend[r] = sb_pkg::FU_NONE;
            end
        end else begin
            if (issued == 0 && (en != 3'b000 || reg_write)) begin
                report_error("unit activity before the first issue");
            end
            if ($countones(en) > 1) begin
                report_error("more than one enable in a cycle");
            end
            for (int i = 0; i < 3; i++) begin
                if (en[i]) begin
                    if (!m_busy[i] || m_read[i]) begin
                        report_error("enable without a waiting entry");
                    end else begin
                        if (m_dep[i] != 3'b000) begin
                            report_error("enable before the producer wrote back");
                        end
                        report_value("unit_op", m_op[i], op_of(i));
                        report_value("rs1_ctrl", m_rs1[i], rs1_ctrl);
                        report_value("rs2_ctrl", m_rs2[i], rs2_ctrl);
                    end
                end
                if (dn[i] && (!m_busy[i] || !m_read[i] || m_done[i])) begin
                    report_error("done pulse without an enabled entry");
                end
            end

            // which unit retires at this edge
            if (reg_write) begin
                w = write_sel;
                if (w > 2 || !m_busy[w] || !m_done[w]) begin
                    report_error("writeback from a unit with no finished entry");
                    w = -1;
                end else begin
                    report_value("rd_ctrl", rd_q[w][0], rd_ctrl);
                    if (rd_q[w][0] == 5'd0) begin
                        report_error("register write for an entry with rd of zero");
                    end
                    for (int j = 0; j < w; j++) begin
                        if (m_busy[j] && m_done[j] && m_rd[j] == 5'd0) begin
                            report_error("writeback priority violated");
                        end
                    end
                end
            end else begin
                for (int j = 2; j >= 0; j--) begin
                    if (m_busy[j] && m_done[j] && m_rd[j] == 5'd0) begin
                        w = j;     // silent retire, lowest index wins
                    end
                end
            end

            if (w >= 0) begin
                for (int j = 0; j < 3; j++) begin
                    if (j != w && m_rd[w] != 5'd0 && m_busy[j] && !m_read[j] &&
                        m_seq[j] < m_seq[w] &&
                        (m_rs1[j] == m_rd[w] || m_rs2[j] == m_rd[w])) begin
                        report_error("writeback before an earlier reader got its operands");
                    end
                end
                void'(rd_q[w].pop_front());
            end

            if (inst_valid) begin
                stall_exp = exp_fu != sb_pkg::FU_NONE &&
                    (m_busy[int'(exp_fu) - 1] ||
                     (exp_rd != 5'd0 && pend[exp_rd] != sb_pkg::FU_NONE));
                report_value("issue_ready", !stall_exp, issue_ready);
            end

            // model update in edge order: read, done, retire, issue
            for (int i = 0; i < 3; i++) begin
                m_read[i] = m_read[i] | en[i];
                m_done[i] = m_done[i] | dn[i];
            end
            if (w >= 0) begin
                m_busy[w] = 1'b0;
                m_read[w] = 1'b0;
                m_done[w] = 1'b0;
                if (int'(pend[m_rd[w]]) == w + 1) begin
                    pend[m_rd[w]] = sb_pkg::FU_NONE;
                end
                for (int j = 0; j < 3; j++) begin
                    m_dep[j][w] = 1'b0;
                end
                wb_count++;
            end
            if (inst_valid && issue_ready && exp_fu != sb_pkg::FU_NONE) begin
                u = int'(exp_fu) - 1;
                m_busy[u] = 1'b1;
                m_read[u] = 1'b0;
                m_done[u] = 1'b0;
                m_op[u]   = exp_op;
                m_rd[u]   = exp_rd;
                m_rs1[u]  = exp_rs1;
                m_rs2[u]  = exp_rs2;
                m_seq[u]  = issued;
                m_dep[u]  = 3'b000;
                if (pend[exp_rs1] != sb_pkg::FU_NONE) m_dep[u][int'(pend[exp_rs1]) - 1] = 1'b1;
                if (pend[exp_rs2] != sb_pkg::FU_NONE) m_dep[u][int'(pend[exp_rs2]) - 1] = 1'b1;
                if (exp_rd != 5'd0) pend[exp_rd] = exp_fu;
                rd_q[u].push_back(exp_rd);
                issued++;
            end
        end
    end

endmodule

/* tests/tb_scoreboard.sv */
`include "sb_defs.svh"

module unit_latency (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    int remaining;

    always @(posedge clk or posedge rst) begin : count
        int lat;
        if (rst) begin
            remaining <= 0;
            done      <= 1'b0;
        end else if (en) begin
            lat = int'($urandom_range(4, 1));   // 1 to 4 cycles
            remaining <= lat - 1;
            done      <= (lat == 1);
        end else if (remaining > 0) begin
            remaining <= remaining - 1;
            done      <= (remaining == 1);
        end else begin
            done <= 1'b0;
        end
    end

endmodule

module tb_scoreboard;
    timeunit 1ns;
    timeprecision 1ps;

    logic          clk;
    logic          rst;
    logic [31:0]   inst;
    logic          inst_valid;
    logic          alu_done, mem_done, mul_done;
    logic          issue_ready;
    logic          alu_en, mem_en, mul_en;
    sb_pkg::op_e   alu_op, mem_op, mul_op;
    logic [4:0]    rs1_ctrl, rs2_ctrl, rd_ctrl;
    logic          reg_write;
    sb_pkg::wsel_e write_sel;
    sb_pkg::fu_e   exp_fu;
    sb_pkg::op_e   exp_op;
    logic [4:0]    exp_rd, exp_rs1, exp_rs2;
    int            errors, issued, wb_count;
    logic          drained;
    int            cycles = 0;
    int            limit = 1000000;
    logic          finished = 1'b0;

    // stimulus table
    logic [31:0]   tbl_inst [$];
    sb_pkg::fu_e   tbl_fu [$];
    sb_pkg::op_e   tbl_op [$];
    logic [4:0]    tbl_rd [$], tbl_rs1 [$], tbl_rs2 [$];

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd, int opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3, int opc);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_u(int imm, int rd, int opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    task automatic add_entry(logic [31:0] word, sb_pkg::fu_e fu, sb_pkg::op_e op,
                             int rd, int rs1, int rs2);
        tbl_inst.push_back(word);
        tbl_fu.push_back(fu);
        tbl_op.push_back(op);
        tbl_rd.push_back(rd[4:0]);
        tbl_rs1.push_back(rs1[4:0]);
        tbl_rs2.push_back(rs2[4:0]);
    endtask

    scoreboard_top dut (.*);

    unit_latency alu_unit (.clk(clk), .rst(rst), .en(alu_en), .done(alu_done));
    unit_latency mem_unit (.clk(clk), .rst(rst), .en(mem_en), .done(mem_done));
    unit_latency mul_unit (.clk(clk), .rst(rst), .en(mul_en), .done(mul_done));

    sb_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) cycles <= cycles + 1;
        if (cycles >= limit && !finished) begin
            $display("timeout: no finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(83));
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        exp_fu     = sb_pkg::FU_NONE;
        exp_op     = sb_pkg::OP_ADD;
        exp_rd     = '0;
        exp_rs1    = '0;
        exp_rs2    = '0;

        add_entry(enc_r(`SB_F7_BASE, 3, 2, `SB_F3_ADD, 1, `SB_OPC_OP),
                  sb_pkg::FU_ALU, sb_pkg::OP_ADD, 1, 2, 3);
        add_entry(enc_r(`SB_F7_ALT, 5, 1, `SB_F3_ADD, 4, `SB_OPC_OP),     // raw on x1
                  sb_pkg::FU_ALU, sb_pkg::OP_SUB, 4, 1, 5);
        add_entry(enc_i(0, 4, `SB_F3_W, 6, `SB_OPC_LOAD),
                  sb_pkg::FU_MEM, sb_pkg::OP_LW, 6, 4, 0);
        add_entry(enc_r(`SB_F7_MULDIV, 6, 6, `SB_F3_MUL, 7, `SB_OPC_OP),
                  sb_pkg::FU_MUL, sb_pkg::OP_MUL, 7, 6, 6);
        add_entry(enc_r(`SB_F7_MULDIV, 2, 1, `SB_F3_MUL, 7, `SB_OPC_OP),  // waw on x7
                  sb_pkg::FU_MUL, sb_pkg::OP_MUL, 7, 1, 2);
        add_entry(enc_i(5, 7, `SB_F3_ADD, 8, `SB_OPC_OPIMM),
                  sb_pkg::FU_ALU, sb_pkg::OP_ADDI, 8, 7, 0);
        add_entry(enc_s(4, 8, 6, `SB_F3_W, `SB_OPC_STORE),
                  sb_pkg::FU_MEM, sb_pkg::OP_SW, 0, 6, 8);
        add_entry(32'hffff_ffff, sb_pkg::FU_NONE, sb_pkg::OP_ADD, 0, 0, 0);
        add_entry(enc_u(20'h12345, 9, `SB_OPC_LUI),
                  sb_pkg::FU_ALU, sb_pkg::OP_LUI, 9, 0, 0);
        add_entry(enc_r(`SB_F7_MULDIV, 8, 9, `SB_F3_MULHU, 10, `SB_OPC_OP),
                  sb_pkg::FU_MUL, sb_pkg::OP_MULHU, 10, 9, 8);
        add_entry(enc_i(0, 10, `SB_F3_BU, 11, `SB_OPC_LOAD),
                  sb_pkg::FU_MEM, sb_pkg::OP_LBU, 11, 10, 0);
        add_entry(enc_i(12'h403, 11, `SB_F3_SR, 12, `SB_OPC_OPIMM),
                  sb_pkg::FU_ALU, sb_pkg::OP_SRAI, 12, 11, 0);
        add_entry(enc_r(`SB_F7_BASE, 2, 1, `SB_F3_ADD, 0, `SB_OPC_OP),     // x0 target
                  sb_pkg::FU_ALU, sb_pkg::OP_ADD, 0, 1, 2);
        add_entry(enc_u(20'h00001, 13, `SB_OPC_AUIPC),
                  sb_pkg::FU_ALU, sb_pkg::OP_AUIPC, 13, 0, 0);
        add_entry(enc_r(`SB_F7_MULDIV, 12, 13, `SB_F3_MULH, 1, `SB_OPC_OP),
                  sb_pkg::FU_MUL, sb_pkg::OP_MULH, 1, 13, 12);
        add_entry(enc_r(`SB_F7_BASE, 1, 1, `SB_F3_XOR, 14, `SB_OPC_OP),
                  sb_pkg::FU_ALU, sb_pkg::OP_XOR, 14, 1, 1);
        limit = tbl_inst.size() * 20;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < tbl_inst.size(); i++) begin
            inst       <= tbl_inst[i];
            inst_valid <= 1'b1;
            exp_fu     <= tbl_fu[i];
            exp_op     <= tbl_op[i];
            exp_rd     <= tbl_rd[i];
            exp_rs1    <= tbl_rs1[i];
            exp_rs2    <= tbl_rs2[i];
            do begin
                @(posedge clk);
            end while (!issue_ready);   // held until accepted
        end
        inst_valid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!drained);
        repeat (2) @(negedge clk);
        finished = 1'b1;
        $display("errors: %0d  issued: %0d  writebacks: %0d", errors, issued, wb_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
design/sb_pkg.sv
design/inst_decoder.sv
design/fu_status_table.sv
design/operand_dispatch.sv
design/writeback_arbiter.sv
design/scoreboard_top.sv
tests/sb_props.sv
tests/sb_checker.sv
tests/tb_scoreboard.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_scoreboard -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
